// ==== logic/mont_defs.svh ====
`ifndef MONT_DEFS_SVH
`define MONT_DEFS_SVH

// Data words per operand, a spare top word sits above these
`define MONT_NUM_WRDS 4

// Bits per word, each word also has one redundant carry bit
`define MONT_WRD_BITS 8

// Odd modulus, kept below R/4 with R = 2**32
`define MONT_P 32'h3a5f_c1e7

// Squaring count width, counts run from 1 to 255
`define MONT_CNT_BITS 8

`endif

// ==== logic/redun_word_pkg.sv ====
`include "mont_defs.svh"

package redun_word_pkg;

  // Binary width of a vector including the spare top word
  localparam int VEC_BITS = (`MONT_NUM_WRDS + 1) * `MONT_WRD_BITS;
  // Width of R
  localparam int R_BITS = `MONT_NUM_WRDS * `MONT_WRD_BITS;

  // One word plus its carry bit in the MSB
  typedef logic [`MONT_WRD_BITS:0] redun_wrd_t;
  // Data words plus spare top word, word 0 is least significant
  typedef redun_wrd_t [`MONT_NUM_WRDS:0] redun_vec_t;
  // Double length multiplier output
  typedef redun_wrd_t [2*`MONT_NUM_WRDS+1:0] redun_prod_t;

  // Spread binary value into words, carries cleared
  function automatic redun_vec_t to_redun(input logic [VEC_BITS-1:0] b);
    redun_vec_t v;
    for (int k = 0; k <= `MONT_NUM_WRDS; k++) begin
      v[k] = {1'b0, b[`MONT_WRD_BITS*k +: `MONT_WRD_BITS]};
    end
    return v;
  endfunction

  // Weighted sum of all words, resolves every carry
  function automatic logic [VEC_BITS-1:0] collapse(input redun_vec_t v);
    logic [VEC_BITS-1:0] acc;
    acc = '0;
    for (int k = 0; k <= `MONT_NUM_WRDS; k++) begin
      acc = acc + (VEC_BITS'(v[k]) << (`MONT_WRD_BITS * k));
    end
    return acc;
  endfunction

  // -P^-1 mod R, Newton steps double the correct bits from 3 up past 32
  function automatic logic [R_BITS-1:0] mont_factor(input logic [R_BITS-1:0] p);
    logic [R_BITS-1:0] inv;
    inv = p;
    for (int i = 0; i < 5; i++) begin
      inv = inv * (2 - p * inv);
    end
    return -inv;
  endfunction

endpackage

// ==== logic/mont_ctl_pkg.sv ====
package mont_ctl_pkg;

  // Number of one-hot state bits
  localparam int NUM_STATES = 4;

  // Bit positions in the one-hot state vector
  typedef enum int {
    IDLE = 0,
    SQR  = 1,
    LOW  = 2,
    HIGH = 3
  } state_idx_e;

  // Multiplier operating modes
  typedef enum logic [1:0] {
    MODE_FULL = 2'd0,
    MODE_LOW  = 2'd1,
    MODE_HIGH = 2'd2
  } mul_mode_e;

endpackage

// ==== logic/mont_job_if.sv ====
`timescale 1ns/1ns
`include "mont_defs.svh"

interface mont_job_if;

  // One-cycle job strobe
  logic val;
  // Operand already in redundant form
  redun_word_pkg::redun_vec_t operand;
  // Squarings to run, never zero
  logic [`MONT_CNT_BITS-1:0] count;
  // Engine level, high while a job runs
  logic busy;

  modport loader (
    output val,
    output operand,
    output count,
    input  busy
  );

  modport engine (
    input  val,
    input  operand,
    input  count,
    output busy
  );

endinterface

// ==== logic/operand_loader.sv ====
`timescale 1ns/1ns
`include "mont_defs.svh"

module operand_loader (
  input  logic                                          i_clk,
  input  logic                                          i_rst,
  input  logic                                          i_start,
  input  logic [`MONT_NUM_WRDS*`MONT_WRD_BITS-1:0]      i_operand,
  input  logic [`MONT_CNT_BITS-1:0]                     i_count,
  mont_job_if.loader                                    job
);

  localparam int WB = `MONT_WRD_BITS;
  localparam int CB = `MONT_CNT_BITS;

  logic accept;

  // Drop starts while busy or while a strobe is still on the bus
  assign accept = i_start & ~job.busy & ~job.val;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      job.val <= 1'b0;
    end else begin
      job.val <= accept;
    end
  end

  // Operand and count held until the next accepted start
  always_ff @(posedge i_clk) begin
    if (accept) begin
      // Spare top word starts out empty
      job.operand <= redun_word_pkg::to_redun({{WB{1'b0}}, i_operand});
      // Zero count runs as one squaring
      job.count   <= (i_count == '0) ? CB'(1) : i_count;
    end
  end

endmodule

// ==== logic/multi_mode_multiplier.sv ====
`timescale 1ns/1ns
`include "mont_defs.svh"

module multi_mode_multiplier (
  input  logic                        i_clk,
  input  mont_ctl_pkg::mul_mode_e     i_mode,
  input  redun_word_pkg::redun_vec_t  i_dat_a,
  input  redun_word_pkg::redun_vec_t  i_dat_b,
  input  redun_word_pkg::redun_vec_t  i_add_term,
  output redun_word_pkg::redun_prod_t o_dat
);

  localparam int NW        = `MONT_NUM_WRDS;
  localparam int WB        = `MONT_WRD_BITS;
  localparam int PROD_BITS = 2 * (NW + 1) * WB;

  // One word-by-word partial product, carries included
  logic [2*WB+1:0] pp;
  logic [PROD_BITS-1:0] acc;
  redun_word_pkg::redun_prod_t prod_nxt;

  // Accumulate all partial products at their word offsets
  always_comb begin
    acc = '0;
    pp  = '0;
    for (int i = 0; i <= NW; i++) begin
      for (int j = 0; j <= NW; j++) begin
        pp  = i_dat_a[i] * i_dat_b[j];
        acc = acc + (PROD_BITS'(pp) << (WB * (i + j)));
      end
    end
  end

  // Mode select on the word slices
  always_comb begin
    prod_nxt = '0;
    unique case (i_mode)
      mont_ctl_pkg::MODE_FULL: begin
        for (int k = 0; k < 2 * (NW + 1); k++) begin
          prod_nxt[k] = {1'b0, acc[WB*k +: WB]};
        end
      end
      // Low words only, this is the product mod R
      mont_ctl_pkg::MODE_LOW: begin
        for (int k = 0; k < NW; k++) begin
          prod_nxt[k] = {1'b0, acc[WB*k +: WB]};
        end
      end
      // Upper words land in the low vector slot, add term goes in word-wise
      // Add term words stay at or below 2**WB so the carry bit holds the sum
      mont_ctl_pkg::MODE_HIGH: begin
        for (int k = 0; k <= NW; k++) begin
          prod_nxt[k] = {1'b0, acc[WB*(k+NW) +: WB]} + i_add_term[k];
        end
      end
      default: begin
        prod_nxt = '0;
      end
    endcase
  end

  // Product register
  always_ff @(posedge i_clk) begin
    o_dat <= prod_nxt;
  end

endmodule

// ==== logic/redun_mont_sq.sv ====
`timescale 1ns/1ns
`include "mont_defs.svh"

module redun_mont_sq (
  input  logic                       i_clk,
  input  logic                       i_rst,
  mont_job_if.engine                 job,
  output logic                       o_res_val,
  output redun_word_pkg::redun_vec_t o_result
);

  localparam int NW = `MONT_NUM_WRDS;
  localparam int WB = `MONT_WRD_BITS;
  localparam int CB = `MONT_CNT_BITS;

  // Constant operands for the LOW and HIGH steps
  localparam redun_word_pkg::redun_vec_t MF_REDUN =
    redun_word_pkg::to_redun({{WB{1'b0}}, redun_word_pkg::mont_factor(`MONT_P)});
  localparam redun_word_pkg::redun_vec_t P_REDUN =
    redun_word_pkg::to_redun({{WB{1'b0}}, `MONT_P});

  logic [mont_ctl_pkg::NUM_STATES-1:0] state, state_nxt;
  // Low in the issue cycle, high in the cycle the product is ready
  logic phase;
  logic [CB-1:0] cnt;
  logic last;
  logic lo_nz;

  mont_ctl_pkg::mul_mode_e mul_mode;
  redun_word_pkg::redun_vec_t mul_a, mul_b;
  redun_word_pkg::redun_prod_t mul_out;
  redun_word_pkg::redun_vec_t prod_lo;

  // Loop registers
  redun_word_pkg::redun_vec_t cur_x, sq_lo, add_hi, m_val;
  redun_word_pkg::redun_vec_t sq_lo_nxt, add_hi_nxt;

  assign last    = (cnt == CB'(1));
  assign prod_lo = mul_out[NW:0];

  // Next state and multiplier operands, held for both phases
  always_comb begin
    state_nxt = '0;
    mul_mode  = mont_ctl_pkg::MODE_FULL;
    mul_a     = cur_x;
    mul_b     = cur_x;
    unique case (1'b1)
      state[mont_ctl_pkg::IDLE]: begin
        if (job.val) state_nxt[mont_ctl_pkg::SQR] = 1'b1;
        else state_nxt[mont_ctl_pkg::IDLE] = 1'b1;
      end
      // Full square of the running value
      state[mont_ctl_pkg::SQR]: begin
        if (phase) state_nxt[mont_ctl_pkg::LOW] = 1'b1;
        else state_nxt[mont_ctl_pkg::SQR] = 1'b1;
      end
      // m = T mod R times the Montgomery factor
      state[mont_ctl_pkg::LOW]: begin
        mul_mode = mont_ctl_pkg::MODE_LOW;
        mul_a    = sq_lo;
        mul_b    = MF_REDUN;
        if (phase) state_nxt[mont_ctl_pkg::HIGH] = 1'b1;
        else state_nxt[mont_ctl_pkg::LOW] = 1'b1;
      end
      // Upper half of m*P plus upper half of T plus carry-in
      state[mont_ctl_pkg::HIGH]: begin
        mul_mode = mont_ctl_pkg::MODE_HIGH;
        mul_a    = m_val;
        mul_b    = P_REDUN;
        if (!phase) state_nxt[mont_ctl_pkg::HIGH] = 1'b1;
        else if (last) state_nxt[mont_ctl_pkg::IDLE] = 1'b1;
        else state_nxt[mont_ctl_pkg::SQR] = 1'b1;
      end
      default: begin
        state_nxt[mont_ctl_pkg::IDLE] = 1'b1;
      end
    endcase
  end

  // Split the square into LOW operand and HIGH add term
  always_comb begin
    sq_lo_nxt = {redun_word_pkg::redun_wrd_t'(0), mul_out[NW-1:0]};
    lo_nz     = |sq_lo_nxt;
    for (int k = 0; k <= NW; k++) begin
      add_hi_nxt[k] = mul_out[k+NW];
    end
    // Low halves of T and m*P sum to R exactly unless T mod R is zero
    add_hi_nxt[0] = add_hi_nxt[0] + lo_nz;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state                     <= '0;
      state[mont_ctl_pkg::IDLE] <= 1'b1;
      phase                     <= 1'b0;
      cnt                       <= '0;
      job.busy                  <= 1'b0;
    end else begin
      state <= state_nxt;
      phase <= state[mont_ctl_pkg::IDLE] ? 1'b0 : ~phase;
      if (state[mont_ctl_pkg::IDLE] && job.val) begin
        job.busy <= 1'b1;
        cnt      <= job.count;
      end else if (state[mont_ctl_pkg::HIGH] && phase) begin
        if (last) job.busy <= 1'b0;
        else cnt <= cnt - CB'(1);
      end
    end
  end

  // Capture each product in the cycle it is ready
  always_ff @(posedge i_clk) begin
    if (state[mont_ctl_pkg::IDLE] && job.val) cur_x <= job.operand;
    if (state[mont_ctl_pkg::SQR] && phase) begin
      sq_lo  <= sq_lo_nxt;
      add_hi <= add_hi_nxt;
    end
    if (state[mont_ctl_pkg::LOW] && phase) m_val <= prod_lo;
    // Stays below 2P thanks to P < R/4, spare word absorbs the top bit
    if (state[mont_ctl_pkg::HIGH] && phase) cur_x <= prod_lo;
  end

  // Result straight off the product register on the last HIGH
  assign o_res_val = state[mont_ctl_pkg::HIGH] & phase & last;
  assign o_result  = prod_lo;

  multi_mode_multiplier u_mul (
    .i_clk      ( i_clk    ),
    .i_mode     ( mul_mode ),
    .i_dat_a    ( mul_a    ),
    .i_dat_b    ( mul_b    ),
    .i_add_term ( add_hi   ),
    .o_dat      ( mul_out  )
  );

endmodule

// ==== logic/result_reduce.sv ====
`timescale 1ns/1ns
`include "mont_defs.svh"

module result_reduce (
  input  logic                                     i_clk,
  input  logic                                     i_rst,
  input  logic                                     i_res_val,
  input  redun_word_pkg::redun_vec_t               i_result,
  output logic                                     o_valid,
  output logic [`MONT_NUM_WRDS*`MONT_WRD_BITS-1:0] o_result
);

  localparam int VB = redun_word_pkg::VEC_BITS;
  localparam int RB = `MONT_NUM_WRDS * `MONT_WRD_BITS;

  // Modulus widened to the collapsed width
  localparam logic [VB-1:0] P_EXT = VB'(`MONT_P);

  logic          val_c;
  logic [VB-1:0] sum_r;
  logic [VB-1:0] diff;

  // Input is below 2P, one subtract is enough
  assign diff = sum_r - P_EXT;

  // Strobe pipeline
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_c   <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      val_c   <= i_res_val;
      o_valid <= val_c;
    end
  end

  always_ff @(posedge i_clk) begin
    // Stage 1, carry collapse
    sum_r <= redun_word_pkg::collapse(i_result);
    // Stage 2, final reduction
    if (sum_r >= P_EXT) begin
      o_result <= diff[RB-1:0];
    end else begin
      o_result <= sum_r[RB-1:0];
    end
  end

endmodule

// ==== logic/mont_sq_top.sv ====
`timescale 1ns/1ns
`include "mont_defs.svh"

module mont_sq_top (
  input  logic                                     i_clk,
  input  logic                                     i_rst,
  input  logic                                     i_start,
  input  logic [`MONT_NUM_WRDS*`MONT_WRD_BITS-1:0] i_operand,
  input  logic [`MONT_CNT_BITS-1:0]                i_count,
  output logic                                     o_valid,
  output logic [`MONT_NUM_WRDS*`MONT_WRD_BITS-1:0] o_result,
  output logic                                     o_busy
);

  // Job bus between loader and engine
  mont_job_if job_bus ();

  // Engine to output side
  logic                       res_val;
  redun_word_pkg::redun_vec_t result;

  operand_loader u_load (
    .i_clk     ( i_clk     ),
    .i_rst     ( i_rst     ),
    .i_start   ( i_start   ),
    .i_operand ( i_operand ),
    .i_count   ( i_count   ),
    .job       ( job_bus   )
  );

  redun_mont_sq u_sq (
    .i_clk     ( i_clk     ),
    .i_rst     ( i_rst     ),
    .job       ( job_bus   ),
    .o_res_val ( res_val   ),
    .o_result  ( result    )
  );

  result_reduce u_red (
    .i_clk     ( i_clk     ),
    .i_rst     ( i_rst     ),
    .i_res_val ( res_val   ),
    .i_result  ( result    ),
    .o_valid   ( o_valid   ),
    .o_result  ( o_result  )
  );

  // Busy level straight from the engine
  assign o_busy = job_bus.busy;

endmodule

// ==== test/mont_sq_props.sv ====
`timescale 1ns/1ns
`include "mont_defs.svh"

module mont_sq_props (
  input logic                                     i_clk,
  input logic                                     i_rst,
  input logic                                     i_valid,
  input logic [`MONT_NUM_WRDS*`MONT_WRD_BITS-1:0] i_result,
  input logic                                     i_busy
);

  // Output strobe is a single-cycle pulse
  a_valid_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    i_valid |=> !i_valid)
    else $error("o_valid stayed high for two cycles");

  // Final reduction leaves the result below the modulus
  a_result_range: assert property (@(posedge i_clk) disable iff (i_rst)
    i_valid |-> (i_result < `MONT_P))
    else $error("o_result not below the modulus while o_valid is high");

  // Engine is already idle once the result leaves
  a_busy_drop: assert property (@(posedge i_clk) disable iff (i_rst)
    i_valid |=> !i_busy)
    else $error("o_busy still high in the cycle after o_valid");

endmodule

bind mont_sq_top mont_sq_props u_props (
  .i_clk    ( i_clk    ),
  .i_rst    ( i_rst    ),
  .i_valid  ( o_valid  ),
  .i_result ( o_result ),
  .i_busy   ( o_busy   )
);

// ==== test/mont_sq_tb.sv ====
`timescale 1ns/1ns
`include "mont_defs.svh"

module mont_sq_tb;

  localparam int RB = `MONT_NUM_WRDS * `MONT_WRD_BITS;
  localparam int CB = `MONT_CNT_BITS;
  localparam logic [RB-1:0] P = `MONT_P;

  logic          i_clk;
  logic          i_rst;
  logic          i_start;
  logic [RB-1:0] i_operand;
  logic [CB-1:0] i_count;
  logic          o_valid;
  logic [RB-1:0] o_result;
  logic          o_busy;
  // LCG state
  logic [31:0]   seed;

  mont_sq_top dut0 (
    .i_clk     ( i_clk     ),
    .i_rst     ( i_rst     ),
    .i_start   ( i_start   ),
    .i_operand ( i_operand ),
    .i_count   ( i_count   ),
    .o_valid   ( o_valid   ),
    .o_result  ( o_result  ),
    .o_busy    ( o_busy    )
  );

  // 40 ns period
  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Square and divide by R one bit at a time with P added on odd values
  function automatic logic [RB-1:0] ref_mont_sq(input logic [RB-1:0] x, input int cnt);
    logic [2*RB-1:0] v;
    logic [RB-1:0]   r;
    r = x;
    for (int n = 0; n < cnt; n++) begin
      v = (2*RB)'(r) * (2*RB)'(r);
      for (int h = 0; h < RB; h++) begin
        if (v[0]) v = v + (2*RB)'(P);
        v = v >> 1;
      end
      while (v >= (2*RB)'(P)) v = v - (2*RB)'(P);
      r = v[RB-1:0];
    end
    return r;
  endfunction

  task automatic fail_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_result(input logic [RB-1:0] got, input logic [RB-1:0] exp);
    if (got !== exp) begin
      $display("ERROR: o_result got %h expected %h", got, exp);
      fail_run();
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR: o_busy got %h expected %h", got, exp);
      fail_run();
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      $display("ERROR: o_valid latency got %h expected %h", got, exp);
      fail_run();
    end
  endtask

  // One-cycle start pulse that returns just after its sampling edge
  task automatic start_job(input logic [RB-1:0] op, input logic [CB-1:0] cnt);
    @(posedge i_clk);
    #1;
    i_start   = 1'b1;
    i_operand = op;
    i_count   = cnt;
    @(posedge i_clk);
    #1;
    i_start   = 1'b0;
  endtask

  // Counts edges from the start edge up to o_valid
  task automatic wait_valid(input int limit, output int cycles);
    cycles = 1;
    while (!o_valid) begin
      if (cycles >= limit) begin
        $display("Timed out waiting for o_valid");
        fail_run();
      end
      @(posedge i_clk);
      #1;
      cycles++;
    end
  endtask

  task automatic wait_busy_high();
    int n;
    n = 0;
    while (!o_busy) begin
      if (n >= 8) begin
        $display("Timed out waiting for o_busy to rise after a start");
        fail_run();
      end
      @(posedge i_clk);
      #1;
      n++;
    end
  endtask

  // No result may appear in this window
  task automatic expect_no_valid(input int n);
    for (int k = 0; k < n; k++) begin
      @(posedge i_clk);
      #1;
      if (o_valid) begin
        $display("o_valid rose although no job was running");
        fail_run();
      end
    end
  endtask

  task automatic run_job(input logic [RB-1:0] op, input logic [CB-1:0] cnt);
    int eff;
    int cycles;
    // Zero count runs once
    eff = (cnt == '0) ? 1 : int'(cnt);
    start_job(op, cnt);
    wait_valid(6 * eff + 20, cycles);
    check_latency(cycles, 6 * eff + 3);
    check_result(o_result, ref_mont_sq(op, eff));
    check_busy(o_busy, 1'b0);
  endtask

  task automatic test_single();
    run_job('0, CB'(1));
    run_job(RB'(1), CB'(1));
    run_job(RB'(2), CB'(1));
    run_job(P - RB'(1), CB'(1));
  endtask

  task automatic test_long_counts();
    run_job(32'h0123_4567, CB'(3));
    run_job(32'h2bad_cafe, CB'(17));
    run_job(32'h1357_9bdf, CB'(255));
  endtask

  // Jobs back to back with each start right after o_valid
  task automatic test_random();
    logic [RB-1:0] op;
    logic [CB-1:0] cnt;
    for (int k = 0; k < 20; k++) begin
      seed = lcg_step(seed);
      op   = seed % P;
      seed = lcg_step(seed);
      cnt  = CB'(1 + (seed >> 16) % 8);
      run_job(op, cnt);
    end
  endtask

  task automatic test_start_while_busy();
    int cycles;
    start_job(32'h0abc_def1, CB'(4));
    wait_busy_high();
    // Second start lands on a busy engine
    i_start   = 1'b1;
    i_operand = 32'h0000_0777;
    i_count   = CB'(1);
    @(posedge i_clk);
    #1;
    i_start   = 1'b0;
    wait_valid(6 * 4 + 20, cycles);
    check_result(o_result, ref_mont_sq(32'h0abc_def1, 4));
    check_busy(o_busy, 1'b0);
    expect_no_valid(20);
  endtask

  task automatic test_mid_reset();
    start_job(32'h3000_0001, CB'(10));
    wait_busy_high();
    repeat (5) @(posedge i_clk);
    #1;
    i_rst = 1'b1;
    repeat (2) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    // Aborted job leaves no trace
    check_busy(o_busy, 1'b0);
    expect_no_valid(6 * 10 + 20);
    run_job(32'h1111_2222, CB'(5));
  endtask

  initial begin
    i_clk     = 1'b0;
    i_rst     = 1'b1;
    i_start   = 1'b0;
    i_operand = '0;
    i_count   = '0;
    seed      = 32'h2a35_d3d7;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    test_single();
    test_long_counts();
    test_random();
    test_start_while_busy();
    // Count of zero
    run_job(32'h0042_4242, '0);
    test_mid_reset();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+logic
logic/redun_word_pkg.sv
logic/mont_ctl_pkg.sv
logic/mont_job_if.sv
logic/operand_loader.sv
logic/multi_mode_multiplier.sv
logic/redun_mont_sq.sv
logic/result_reduce.sv
logic/mont_sq_top.sv
test/mont_sq_props.sv
test/mont_sq_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mont_sq_tb
FILELIST = project.f
BUILD    = obj_dir

SIM = $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard logic/*.sv logic/*.svh test/*.sv)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD)
